// ==== verilog/periph_pkg.sv ====
//********************************************************************
// Peripheral hub definitions
// Bus widths, access sizes, request/response structs and the address map
//********************************************************************
`default_nettype none

package periph_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  addr_t;
    typedef logic [4:0]  offset_t;
    typedef logic [7:0]  pins_t;
    // Pin function select, bit 2 picks a simple slot, bits 1:0 the slot index
    typedef logic [2:0]  sel_t;

    // Request size codes as the core drives them, 3 means idle
    typedef enum logic [1:0] {
        ACC_BYTE = 2'd0,
        ACC_HALF = 2'd1,
        ACC_WORD = 2'd2,
        ACC_NONE = 2'd3
    } access_t;

    typedef struct packed {
        offset_t offset;
        word_t   wdata;
        access_t write;
        access_t read;
    } periph_req_t;

    typedef struct packed {
        word_t rdata;
        logic  ready;
    } periph_rsp_t;

    typedef struct packed {
        logic [3:0] offset;
        byte_t      wdata;
        logic       write;
    } simple_req_t;

    localparam int NUM_USER     = 4;
    localparam int NUM_SIMPLE   = 4;
    localparam int SLOT_GPIO    = 1;
    localparam int SLOT_TIMER_A = 2;
    localparam int SLOT_TIMER_B = 3;

    localparam offset_t TMR_COUNT   = 5'd0;
    localparam offset_t TMR_COMPARE = 5'd4;
    localparam offset_t TMR_CTRL    = 5'd8;

    localparam offset_t GPIO_OUT      = 5'd0;
    localparam offset_t GPIO_IN       = 5'd4;
    // Pin n select sits at GPIO_SEL_BASE + 2*n so all eight fit in the slot
    localparam offset_t GPIO_SEL_BASE = 5'd16;

    localparam sel_t SEL_GPIO    = 3'd1;
    localparam sel_t SEL_TIMER_A = 3'd2;

endpackage

`default_nettype wire

// ==== verilog/periph_hub.sv ====
//********************************************************************
// Peripheral hub
// Address decode, request gating and registered read data for the core
//********************************************************************
`default_nettype none

module periph_hub (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire periph_pkg::addr_t       addr,
    input  wire periph_pkg::word_t       wdata,
    input  wire periph_pkg::access_t     write_n,
    input  wire periph_pkg::access_t     read_n,
    input  wire logic                    read_complete,

    output periph_pkg::word_t            rdata,
    output logic                         data_ready,

    output periph_pkg::periph_req_t      user_req [periph_pkg::NUM_USER],
    input  wire periph_pkg::periph_rsp_t user_rsp [periph_pkg::NUM_USER],

    output periph_pkg::simple_req_t      simple_req [periph_pkg::NUM_SIMPLE],
    input  wire periph_pkg::byte_t       simple_rdata [periph_pkg::NUM_SIMPLE]
);

    logic              is_simple;
    logic [1:0]        user_idx;
    logic [1:0]        simple_idx;
    logic              read_req;
    logic              write_req;

    periph_pkg::word_t sel_rdata;
    logic              sel_ready;

    logic              hold;
    logic              hold_d;
    logic              capture;
    logic              data_ready_r;
    periph_pkg::word_t rdata_r;

    // Bit 7 splits the map into user slots and simple slots
    assign is_simple  = addr[7];
    assign user_idx   = addr[6:5];
    assign simple_idx = addr[5:4];

    assign read_req  = read_n != periph_pkg::ACC_NONE;
    assign write_req = write_n != periph_pkg::ACC_NONE;

    // Only the selected user slot sees a request.
    // Reads are masked while a result is being held for the core
    always_comb begin
        for (int i = 0; i < periph_pkg::NUM_USER; i++) begin
            user_req[i].offset = addr[4:0];
            user_req[i].wdata  = wdata;
            user_req[i].write  = periph_pkg::ACC_NONE;
            user_req[i].read   = periph_pkg::ACC_NONE;
            if (!is_simple && user_idx == 2'(i)) begin
                user_req[i].write = write_n;
                if (!hold) begin
                    user_req[i].read = read_n;
                end
            end
        end
    end

    // Simple slots only ever see the low byte
    always_comb begin
        for (int i = 0; i < periph_pkg::NUM_SIMPLE; i++) begin
            simple_req[i].offset = addr[3:0];
            simple_req[i].wdata  = wdata[7:0];
            simple_req[i].write  = is_simple && simple_idx == 2'(i) && write_req;
        end
    end

    // Response of the addressed slot, simple slots are always ready
    always_comb begin
        if (is_simple) begin
            sel_rdata = {24'h0, simple_rdata[simple_idx]};
            sel_ready = 1'b1;
        end else begin
            sel_rdata = user_rsp[user_idx].rdata;
            sel_ready = user_rsp[user_idx].ready;
        end
    end

    // First ready of an active read is captured and held until read_complete
    assign capture = !hold && read_req && sel_ready;
    assign hold_d  = (hold && !read_complete) || capture;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold         <= 1'b0;
            data_ready_r <= 1'b0;
        end else begin
            hold         <= hold_d;
            data_ready_r <= read_req && hold_d;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_r <= sel_rdata;
        end
    end

    assign rdata = rdata_r;

    // Writes never wait
    assign data_ready = data_ready_r || write_req;

endmodule

`default_nettype wire

// ==== verilog/gpio_ctrl.sv ====
//********************************************************************
// GPIO controller
// Output register, per-pin function selects and the output pin mux
//********************************************************************
`default_nettype none

module gpio_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire periph_pkg::periph_req_t req,
    output periph_pkg::periph_rsp_t      rsp,

    input  wire periph_pkg::pins_t       ui_in,
    input  wire periph_pkg::pins_t       user_pins [periph_pkg::NUM_USER],
    input  wire periph_pkg::pins_t       simple_pins [periph_pkg::NUM_SIMPLE],

    output periph_pkg::pins_t            uo_out
);

    periph_pkg::byte_t gpio_out;
    periph_pkg::sel_t  func_sel [8];

    logic              write_en;
    logic              sel_hit;
    logic [2:0]        sel_pin;

    assign write_en = req.write != periph_pkg::ACC_NONE;

    // Select registers are halfword spaced from GPIO_SEL_BASE
    assign sel_hit = (req.offset & 5'b10001) == periph_pkg::GPIO_SEL_BASE;
    assign sel_pin = req.offset[3:1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int i = 0; i < 8; i++) begin
                func_sel[i] <= (i == 7) ? periph_pkg::SEL_TIMER_A : periph_pkg::SEL_GPIO;
            end
        end else if (write_en) begin
            if (req.offset == periph_pkg::GPIO_OUT) begin
                gpio_out <= req.wdata[7:0];
            end
            if (sel_hit) begin
                func_sel[sel_pin] <= req.wdata[2:0];
            end
        end
    end

    // Reads are combinational, the hub registers them
    always_comb begin
        rsp.ready = 1'b1;
        if (req.offset == periph_pkg::GPIO_OUT) begin
            rsp.rdata = {24'h0, gpio_out};
        end else if (req.offset == periph_pkg::GPIO_IN) begin
            rsp.rdata = {24'h0, ui_in};
        end else if (sel_hit) begin
            rsp.rdata = {29'h0, func_sel[sel_pin]};
        end else begin
            rsp.rdata = '0;
        end
    end

    // Each pin takes its own bit from the peripheral its select names
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            if (func_sel[i][2]) begin
                uo_out[i] = simple_pins[func_sel[i][1:0]][i];
            end else if (func_sel[i][1:0] == 2'(periph_pkg::SLOT_GPIO)) begin
                uo_out[i] = gpio_out[i];
            end else begin
                uo_out[i] = user_pins[func_sel[i][1:0]][i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cmp_timer.sv ====
//********************************************************************
// Compare timer
// Free-running counter that wraps on compare, toggles a pin and flags irq
//********************************************************************
`default_nettype none

module cmp_timer #(
    parameter int COUNT_WIDTH = 16
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire periph_pkg::periph_req_t req,
    output periph_pkg::periph_rsp_t      rsp,

    output periph_pkg::pins_t            pins,
    output logic                         irq
);

    logic [COUNT_WIDTH-1:0] count;
    logic [COUNT_WIDTH-1:0] compare;
    logic                   enable;
    logic                   irq_r;
    logic                   toggle;
    logic                   write_en;
    periph_pkg::word_t      rd_word;

    // Merge a write of the given size into a register, upper bits dropped
    function automatic logic [COUNT_WIDTH-1:0] merge_write(
        input logic [COUNT_WIDTH-1:0] cur,
        input periph_pkg::word_t      wd,
        input periph_pkg::access_t    size
    );
        periph_pkg::word_t full;
        full = '0;
        full[COUNT_WIDTH-1:0] = cur;
        case (size)
            periph_pkg::ACC_BYTE: full[7:0] = wd[7:0];
            periph_pkg::ACC_HALF: full[15:0] = wd[15:0];
            periph_pkg::ACC_WORD: full = wd;
            default: full = full;
        endcase
        return full[COUNT_WIDTH-1:0];
    endfunction

    assign write_en = req.write != periph_pkg::ACC_NONE;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count   <= '0;
            compare <= '1;
            enable  <= 1'b0;
            irq_r   <= 1'b0;
            toggle  <= 1'b0;
        end else begin
            if (write_en && req.offset == periph_pkg::TMR_CTRL) begin
                enable <= req.wdata[0];
                if (req.wdata[1]) begin
                    irq_r <= 1'b0;
                end
            end
            if (write_en && req.offset == periph_pkg::TMR_COMPARE) begin
                compare <= merge_write(compare, req.wdata, req.write);
            end
            // A count write wins over counting in that cycle
            if (write_en && req.offset == periph_pkg::TMR_COUNT) begin
                count <= merge_write(count, req.wdata, req.write);
            end else if (enable) begin
                if (count == compare) begin
                    count  <= '0;
                    irq_r  <= 1'b1;
                    toggle <= ~toggle;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (req.offset)
            periph_pkg::TMR_COUNT:   rd_word[COUNT_WIDTH-1:0] = count;
            periph_pkg::TMR_COMPARE: rd_word[COUNT_WIDTH-1:0] = compare;
            periph_pkg::TMR_CTRL:    rd_word[1:0] = {irq_r, enable};
            default:                 rd_word = '0;
        endcase
    end

    // Read data shows up one cycle after the request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp.ready <= 1'b0;
        end else begin
            rsp.ready <= req.read != periph_pkg::ACC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        rsp.rdata <= rd_word;
    end

    assign pins = {8{toggle}};
    assign irq  = irq_r;

endmodule

`default_nettype wire

// ==== verilog/byte_regs.sv ====
//********************************************************************
// Simple byte register bank
// Four byte registers, register 0 drives the output pins
//********************************************************************
`default_nettype none

module byte_regs #(
    parameter periph_pkg::byte_t RESET_VALUE = 8'h00
) (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire periph_pkg::simple_req_t req,
    output periph_pkg::byte_t            rdata,
    output periph_pkg::pins_t            pins
);

    periph_pkg::byte_t regs [4];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= RESET_VALUE;
            end
        end else if (req.write && req.offset[3:2] == 2'b00) begin
            regs[req.offset[1:0]] <= req.wdata;
        end
    end

    // Offsets past the bank read as all ones
    assign rdata = (req.offset[3:2] == 2'b00) ? regs[req.offset[1:0]] : 8'hFF;
    assign pins  = regs[0];

endmodule

`default_nettype wire

// ==== verilog/periph_top.sv ====
//********************************************************************
// Peripheral subsystem top
// Hub, GPIO, two compare timers and four byte banks
//********************************************************************
`default_nettype none

module periph_top #(
    parameter int TIMER_A_WIDTH = 16,
    parameter int TIMER_B_WIDTH = 8
) (
    input  wire logic                clk,
    input  wire logic                rst_n,

    input  wire periph_pkg::addr_t   addr,
    input  wire periph_pkg::word_t   wdata,
    input  wire periph_pkg::access_t write_n,
    input  wire periph_pkg::access_t read_n,
    input  wire logic                read_complete,

    input  wire periph_pkg::pins_t   ui_in,
    output periph_pkg::pins_t        uo_out,

    output periph_pkg::word_t        rdata,
    output logic                     data_ready,
    output logic [1:0]               irq
);

    periph_pkg::periph_req_t user_req [periph_pkg::NUM_USER];
    periph_pkg::periph_rsp_t user_rsp [periph_pkg::NUM_USER];
    periph_pkg::simple_req_t simple_req [periph_pkg::NUM_SIMPLE];
    periph_pkg::byte_t       simple_rdata [periph_pkg::NUM_SIMPLE];
    periph_pkg::pins_t       user_pins [periph_pkg::NUM_USER];
    periph_pkg::pins_t       simple_pins [periph_pkg::NUM_SIMPLE];

    // Slot 0 is empty, GPIO drives its own pins inside gpio_ctrl
    assign user_rsp[0]  = '{rdata: '0, ready: 1'b1};
    assign user_pins[0] = '0;
    assign user_pins[periph_pkg::SLOT_GPIO] = '0;

    periph_hub u_hub (
        .clk           (clk),
        .rst_n         (rst_n),
        .addr          (addr),
        .wdata         (wdata),
        .write_n       (write_n),
        .read_n        (read_n),
        .read_complete (read_complete),
        .rdata         (rdata),
        .data_ready    (data_ready),
        .user_req      (user_req),
        .user_rsp      (user_rsp),
        .simple_req    (simple_req),
        .simple_rdata  (simple_rdata)
    );

    gpio_ctrl u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (user_req[periph_pkg::SLOT_GPIO]),
        .rsp         (user_rsp[periph_pkg::SLOT_GPIO]),
        .ui_in       (ui_in),
        .user_pins   (user_pins),
        .simple_pins (simple_pins),
        .uo_out      (uo_out)
    );

    cmp_timer #(.COUNT_WIDTH(TIMER_A_WIDTH)) u_timer_a (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (user_req[periph_pkg::SLOT_TIMER_A]),
        .rsp   (user_rsp[periph_pkg::SLOT_TIMER_A]),
        .pins  (user_pins[periph_pkg::SLOT_TIMER_A]),
        .irq   (irq[0])
    );

    cmp_timer #(.COUNT_WIDTH(TIMER_B_WIDTH)) u_timer_b (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (user_req[periph_pkg::SLOT_TIMER_B]),
        .rsp   (user_rsp[periph_pkg::SLOT_TIMER_B]),
        .pins  (user_pins[periph_pkg::SLOT_TIMER_B]),
        .irq   (irq[1])
    );

    // Banks reset to 0x10, 0x20, 0x30 and 0x40
    for (genvar g = 0; g < periph_pkg::NUM_SIMPLE; g++) begin : g_bank
        byte_regs #(.RESET_VALUE(8'((g + 1) * 16))) u_bank (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (simple_req[g]),
            .rdata (simple_rdata[g]),
            .pins  (simple_pins[g])
        );
    end

endmodule

`default_nettype wire

// ==== sim/tb_periph_top.sv ====
//**********************************************************************
// Peripheral subsystem testbench
// Table of bus steps applied to the hub, GPIO, timers and byte banks
//**********************************************************************
`default_nettype none

module tb_periph_top;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_PINS,
        OP_IRQ,
        OP_WAIT_IRQ
    } op_t;

    typedef struct {
        op_t                 op;
        periph_pkg::addr_t   addr;
        periph_pkg::access_t size;
        periph_pkg::word_t   data;
        periph_pkg::word_t   exp_val;
    } step_t;

    logic                clk;
    logic                rst_n;
    periph_pkg::addr_t   addr;
    periph_pkg::word_t   wdata;
    periph_pkg::access_t write_n;
    periph_pkg::access_t read_n;
    logic                read_complete;
    periph_pkg::pins_t   ui_in;
    periph_pkg::pins_t   uo_out;
    periph_pkg::word_t   rdata;
    logic                data_ready;
    logic [1:0]          irq;

    step_t               steps[$];
    logic                table_built;

    periph_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .addr          (addr),
        .wdata         (wdata),
        .write_n       (write_n),
        .read_n        (read_n),
        .read_complete (read_complete),
        .ui_in         (ui_in),
        .uo_out        (uo_out),
        .rdata         (rdata),
        .data_ready    (data_ready),
        .irq           (irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic periph_pkg::addr_t user_addr(input int slot,
                                                    input periph_pkg::offset_t off);
        return {1'b0, 2'(slot), off};
    endfunction

    function automatic periph_pkg::addr_t simple_addr(input int slot,
                                                      input logic [3:0] off);
        return {2'b10, 2'(slot), off};
    endfunction

    // Bits a write of the given size can reach
    function automatic periph_pkg::word_t size_mask(input periph_pkg::access_t size);
        case (size)
            periph_pkg::ACC_BYTE: return 32'h0000_00FF;
            periph_pkg::ACC_HALF: return 32'h0000_FFFF;
            default:              return 32'hFFFF_FFFF;
        endcase
    endfunction

    function automatic void add_step(input op_t op, input periph_pkg::addr_t a,
                                     input periph_pkg::access_t size,
                                     input periph_pkg::word_t d, input periph_pkg::word_t e);
        step_t s;
        s.op      = op;
        s.addr    = a;
        s.size    = size;
        s.data    = d;
        s.exp_val = e;
        steps.push_back(s);
    endfunction

    task automatic check_value(input periph_pkg::word_t got, input periph_pkg::word_t exp_v,
                               input string what);
        if (got !== exp_v) begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp_v);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Single cycle write
    // data_ready must already be high in that cycle
    task automatic bus_write(input periph_pkg::addr_t a, input periph_pkg::access_t size,
                             input periph_pkg::word_t d);
        addr    = a;
        wdata   = d;
        write_n = size;
        @(negedge clk);
        check_value({31'h0, data_ready}, 32'h1, "data_ready during write");
        @(posedge clk);
        #5;
        write_n = periph_pkg::ACC_NONE;
    endtask

    task automatic bus_read(input periph_pkg::addr_t a, input periph_pkg::access_t size,
                            output periph_pkg::word_t got);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        addr   = a;
        read_n = size;
        while (!done && cycles < 8) begin
            @(posedge clk);
            #5;
            cycles++;
            done = data_ready;
        end
        if (!done) begin
            $display("Read of address %h got no data_ready within 8 cycles", a);
            $display("Simulation FAILED");
            $fatal(1, "read timeout");
        end else begin
            got           = rdata;
            read_n        = periph_pkg::ACC_NONE;
            read_complete = 1'b1;
            @(posedge clk);
            #5;
            read_complete = 1'b0;
        end
    endtask

    task automatic wait_for_irq();
        int cycles;
        cycles = 0;
        while (irq[0] !== 1'b1 && cycles < 30) begin
            check_value({31'h0, irq[1]}, 32'h0, "timer B irq while polling");
            @(posedge clk);
            #5;
            cycles++;
        end
        if (irq[0] !== 1'b1) begin
            $display("Timer A interrupt did not rise within 30 cycles");
            $display("Simulation FAILED");
            $fatal(1, "irq timeout");
        end
    endtask

    task automatic build_table(input periph_pkg::byte_t ui_val);
        periph_pkg::word_t   r;
        periph_pkg::word_t   wmask;
        periph_pkg::byte_t   gpio_val;
        periph_pkg::byte_t   bank_val;
        periph_pkg::addr_t   tbase;
        periph_pkg::addr_t   sel3;
        periph_pkg::word_t   bank_exp [4][4];
        periph_pkg::access_t sizes [3];
        sizes = '{periph_pkg::ACC_BYTE, periph_pkg::ACC_HALF, periph_pkg::ACC_WORD};
        sel3  = user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_SEL_BASE + 5'd6);

        // Reset state
        add_step(OP_PINS, 8'h00, periph_pkg::ACC_NONE, 32'h0, 32'h0);
        for (int b = 0; b < 4; b++) begin
            add_step(OP_READ, simple_addr(b, 4'd0), periph_pkg::ACC_BYTE, 32'h0,
                     32'((b + 1) * 16));
        end
        add_step(OP_READ, user_addr(0, 5'd0), periph_pkg::ACC_WORD, 32'h0, 32'h0);
        add_step(OP_READ, user_addr(0, 5'd12), periph_pkg::ACC_WORD, 32'h0, 32'h0);
        add_step(OP_READ, user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_IN),
                 periph_pkg::ACC_WORD, 32'h0, {24'h0, ui_val});

        // GPIO output path
        // Pin 7 stays on the idle timer A pin
        r        = $urandom;
        gpio_val = r[7:0];
        add_step(OP_WRITE, user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OUT),
                 periph_pkg::ACC_WORD, r, 32'h0);
        add_step(OP_READ, user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_OUT),
                 periph_pkg::ACC_WORD, 32'h0, {24'h0, gpio_val});
        add_step(OP_PINS, 8'h00, periph_pkg::ACC_NONE, 32'h0, {24'h0, 1'b0, gpio_val[6:0]});
        add_step(OP_READ, user_addr(periph_pkg::SLOT_GPIO, periph_pkg::GPIO_SEL_BASE + 5'd14),
                 periph_pkg::ACC_WORD, 32'h0, 32'h2);
        r        = $urandom;
        bank_val = r[7:0];
        add_step(OP_WRITE, simple_addr(1, 4'd0), periph_pkg::ACC_BYTE, r, 32'h0);
        add_step(OP_WRITE, sel3, periph_pkg::ACC_WORD, 32'h5, 32'h0);
        add_step(OP_READ, sel3, periph_pkg::ACC_WORD, 32'h0, 32'h5);
        add_step(OP_PINS, 8'h00, periph_pkg::ACC_NONE, 32'h0,
                 {24'h0, 1'b0, gpio_val[6:4], bank_val[3], gpio_val[2:0]});

        // Byte banks keep only the low byte
        for (int b = 0; b < 4; b++) begin
            for (int o = 0; o < 4; o++) begin
                r = $urandom;
                bank_exp[b][o] = r & 32'hFF;
                add_step(OP_WRITE, simple_addr(b, 4'(o)), periph_pkg::ACC_BYTE, r, 32'h0);
            end
        end
        for (int b = 0; b < 4; b++) begin
            for (int o = 0; o < 4; o++) begin
                add_step(OP_READ, simple_addr(b, 4'(o)), periph_pkg::ACC_BYTE, 32'h0,
                         bank_exp[b][o]);
            end
            add_step(OP_READ, simple_addr(b, 4'd9), periph_pkg::ACC_BYTE, 32'h0, 32'hFF);
        end

        // Timer count writes of each size
        // Timer A keeps 16 bits and timer B 8
        for (int t = 0; t < 2; t++) begin
            tbase = user_addr(periph_pkg::SLOT_TIMER_A + t, periph_pkg::TMR_COUNT);
            wmask = (t == 0) ? 32'h0000_FFFF : 32'h0000_00FF;
            r     = $urandom;
            add_step(OP_WRITE, tbase, periph_pkg::ACC_WORD, 32'h0, 32'h0);
            for (int s = 0; s < 3; s++) begin
                add_step(OP_WRITE, tbase, sizes[s], r, 32'h0);
                add_step(OP_READ, tbase, periph_pkg::ACC_WORD, 32'h0,
                         r & size_mask(sizes[s]) & wmask);
            end
        end

        // Timer A interrupt
        tbase = user_addr(periph_pkg::SLOT_TIMER_A, 5'd0);
        add_step(OP_WRITE, tbase + periph_pkg::TMR_COUNT, periph_pkg::ACC_WORD, 32'h0, 32'h0);
        add_step(OP_WRITE, tbase + periph_pkg::TMR_COMPARE, periph_pkg::ACC_WORD, 32'h5, 32'h0);
        add_step(OP_WRITE, tbase + periph_pkg::TMR_CTRL, periph_pkg::ACC_WORD, 32'h1, 32'h0);
        add_step(OP_WAIT_IRQ, 8'h00, periph_pkg::ACC_NONE, 32'h0, 32'h0);
        add_step(OP_IRQ, 8'h00, periph_pkg::ACC_NONE, 32'h0, 32'h1);
        // Timer A toggled its pin on the match that raised irq
        add_step(OP_PINS, 8'h00, periph_pkg::ACC_NONE, 32'h0,
                 {24'h0, 1'b1, gpio_val[6:4], bank_exp[1][0][3], gpio_val[2:0]});
        add_step(OP_READ, tbase + periph_pkg::TMR_CTRL, periph_pkg::ACC_WORD, 32'h0, 32'h3);
        add_step(OP_WRITE, tbase + periph_pkg::TMR_CTRL, periph_pkg::ACC_WORD, 32'h3, 32'h0);
        add_step(OP_IRQ, 8'h00, periph_pkg::ACC_NONE, 32'h0, 32'h0);
    endtask

    task automatic run_step(input step_t s, input int idx);
        periph_pkg::word_t got;
        case (s.op)
            OP_WRITE:    bus_write(s.addr, s.size, s.data);
            OP_READ: begin
                bus_read(s.addr, s.size, got);
                check_value(got, s.exp_val, $sformatf("step %0d read of %h", idx, s.addr));
            end
            OP_PINS:     check_value({24'h0, uo_out}, s.exp_val, $sformatf("step %0d uo_out", idx));
            OP_IRQ:      check_value({30'h0, irq}, s.exp_val, $sformatf("step %0d irq", idx));
            default:     wait_for_irq();
        endcase
    endtask

    // Watchdog allows about 20 cycles per table step
    initial begin
        longint unsigned limit;
        wait (table_built === 1'b1);
        limit = 64'(steps.size()) * 20 * 40;
        #(limit);
        $display("Watchdog expired before the test table finished");
        $display("Simulation FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        periph_pkg::word_t r;
        void'($urandom(69177));
        table_built   = 1'b0;
        rst_n         = 1'b0;
        addr          = '0;
        wdata         = '0;
        write_n       = periph_pkg::ACC_NONE;
        read_n        = periph_pkg::ACC_NONE;
        read_complete = 1'b0;
        r             = $urandom;
        ui_in         = r[7:0];
        build_table(r[7:0]);
        table_built   = 1'b1;

        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;

        foreach (steps[i]) begin
            run_step(steps[i], i);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/periph_pkg.sv
verilog/periph_hub.sv
verilog/gpio_ctrl.sv
verilog/cmp_timer.sv
verilog/byte_regs.sv
verilog/periph_top.sv
sim/tb_periph_top.sv

// ==== Makefile ====
TOP := tb_periph_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f flist.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

lint:
	verilator --lint-only --top-module periph_top \
	    verilog/periph_pkg.sv verilog/periph_hub.sv verilog/gpio_ctrl.sv \
	    verilog/cmp_timer.sv verilog/byte_regs.sv verilog/periph_top.sv
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir
